/* common/sdmac_config.svh */
// Register map and acknowledge timing for the SDMAC host register block.
// Offsets are byte addresses on addr[7:0]. Delays are counted in CLK cycles.
`ifndef SDMAC_CONFIG_SVH
`define SDMAC_CONFIG_SVH

`define SDMAC_OFS_WTC      8'h04  // Word transfer count
`define SDMAC_OFS_CNTR     8'h08  // Control register
`define SDMAC_OFS_ACR      8'h0C  // Auxiliary control
`define SDMAC_OFS_ST_DMA   8'h10  // Start DMA strobe
`define SDMAC_OFS_FLUSH    8'h14  // FIFO flush strobe
`define SDMAC_OFS_CINT     8'h18  // Clear interrupts strobe
`define SDMAC_OFS_ISTR     8'h1C  // Interrupt status
`define SDMAC_OFS_SP_DMA   8'h3C  // Stop DMA strobe
`define SDMAC_OFS_SSPBDAT  8'h58  // Scratch/peripheral data

`define SDMAC_WD_LO        8'h40  // SCSI chip window, low end
`define SDMAC_WD_HI        8'h4F  // SCSI chip window, high end

`define SDMAC_WTC_VALUE    32'd4  // WTC always reads this
`define SDMAC_DSACK_DLY      3    // Normal acknowledge delay
`define SDMAC_DSACK_DLY_ACR  5    // Slower for ACR writes
`define SDMAC_DATA_W        32    // CPU data bus width

`endif

/* common/sdmac_reg_pkg.sv */
// Field layout of the control and status registers.
// Both are 9 bits wide and zero-extended onto the data bus.
`default_nettype none

package sdmac_reg_pkg;

  // Control register, stored as written
  typedef struct packed {
    logic [3:0] rsvd_hi;    // Bits 8:5, stored only
    logic       preset;     // Peripheral reset
    logic       rsvd3;      // Stored only
    logic       intena;     // Interrupt enable
    logic       dmadir;     // DMA direction
    logic       rsvd0;      // Stored only
  } cntr_t;

  // Interrupt status register
  typedef struct packed {
    logic       int_f;      // Pending and enabled
    logic [2:0] rsvd_hi;    // Read as 0
    logic       intp;       // Interrupt pending
    logic [1:0] rsvd_lo;    // Read as 0
    logic       fifo_full;
    logic       fifo_empty;
  } istr_t;

endpackage

`default_nettype wire

/* common/sdmac_bus_pkg.sv */
// Bus side definitions for the host register block.
`default_nettype none

package sdmac_bus_pkg;

  // Read target picked by the decoder
  typedef enum logic [2:0] {
    SEL_NONE    = 3'd0,  // Not a readable register, bus reads 0
    SEL_WTC     = 3'd1,
    SEL_CNTR    = 3'd2,
    SEL_ISTR    = 3'd3,
    SEL_SSPBDAT = 3'd4
  } reg_sel_e;

endpackage

`default_nettype wire

/* registers/addr_decoder.sv */
// Decodes CPU accesses into read selects, write pulses and window levels.
// Action strobes fire on the first cycle of any access, read or write.
`include "sdmac_config.svh"
`default_nettype none

module addr_decoder (
  input  wire logic               CLK,
  input  wire logic               RST_,
  input  wire logic [7:0]         addr,
  input  wire logic               dmac_,     // Chip select
  input  wire logic               as_,       // Address strobe
  input  wire logic               rw,        // High for read
  output sdmac_bus_pkg::reg_sel_e reg_sel,
  output logic                    cntr_wr,
  output logic                    acr_wr,
  output logic                    sspbdat_wr,
  output logic                    st_dma,
  output logic                    sp_dma,
  output logic                    clr_int,
  output logic                    flush,
  output logic                    istr_rd,
  output logic                    h_0c,
  output logic                    wdregreq
);
  import sdmac_bus_pkg::*;

  logic access;    // Strobe and select both low
  logic seen;      // Access already past its first edge
  logic first;
  logic wr_first;

  assign access   = ~as_ & ~dmac_;
  assign first    = access & ~seen;  // High only until the first edge
  assign wr_first = first & ~rw;

  always_ff @(posedge CLK) begin
    if (!RST_) begin
      seen <= 1'b0;
    end else begin
      seen <= access;  // Drops again once as_ rises
    end
  end

  // One pulse per access
  assign cntr_wr    = wr_first & (addr == `SDMAC_OFS_CNTR);
  assign acr_wr     = wr_first & (addr == `SDMAC_OFS_ACR);
  assign sspbdat_wr = wr_first & (addr == `SDMAC_OFS_SSPBDAT);
  assign st_dma     = first & (addr == `SDMAC_OFS_ST_DMA);
  assign sp_dma     = first & (addr == `SDMAC_OFS_SP_DMA);
  assign clr_int    = first & (addr == `SDMAC_OFS_CINT);
  assign flush      = first & (addr == `SDMAC_OFS_FLUSH);

  // Levels held for the whole access
  assign istr_rd  = access & rw & (addr == `SDMAC_OFS_ISTR);
  assign h_0c     = access & (addr == `SDMAC_OFS_ACR);
  assign wdregreq = access & (addr >= `SDMAC_WD_LO) & (addr <= `SDMAC_WD_HI);

  always_comb begin
    reg_sel = SEL_NONE;
    if (access && rw) begin
      case (addr)
        `SDMAC_OFS_WTC:     reg_sel = SEL_WTC;
        `SDMAC_OFS_CNTR:    reg_sel = SEL_CNTR;
        `SDMAC_OFS_ISTR:    reg_sel = SEL_ISTR;
        `SDMAC_OFS_SSPBDAT: reg_sel = SEL_SSPBDAT;
        default:            reg_sel = SEL_NONE;  // Strobes and window read 0
      endcase
    end
  end

endmodule

`default_nettype wire

/* registers/registers_cntr.sv */
// Control register and DMA enable flag.
// Stop DMA wins over start DMA when both arrive together.
`default_nettype none

module registers_cntr (
  input  wire logic           CLK,
  input  wire logic           RST_,
  input  wire logic           cntr_wr,
  input  wire logic           st_dma,
  input  wire logic           sp_dma,
  input  wire logic [8:0]     mid,       // Low bits of CPU write data
  output sdmac_reg_pkg::cntr_t cntr_o,
  output logic                intena,
  output logic                preset,
  output logic                dmadir,
  output logic                dmaena
);
  import sdmac_reg_pkg::*;

  always_ff @(posedge CLK) begin
    if (!RST_) begin
      cntr_o <= '0;
    end else if (cntr_wr) begin
      cntr_o <= cntr_t'(mid);  // All 9 bits kept for readback
    end
  end

  // DMA enable, set and cleared by action strobes only
  always_ff @(posedge CLK) begin
    if (!RST_) begin
      dmaena <= 1'b0;
    end else if (sp_dma) begin
      dmaena <= 1'b0;
    end else if (st_dma) begin
      dmaena <= 1'b1;
    end
  end

  // Named fields straight out
  assign intena = cntr_o.intena;
  assign preset = cntr_o.preset;  // Held while bit set
  assign dmadir = cntr_o.dmadir;

endmodule

`default_nettype wire

/* registers/registers_istr.sv */
// Interrupt pending latch and status register.
// Pending cannot be cleared while inta_i is still high.
`default_nettype none

module registers_istr (
  input  wire logic           CLK,
  input  wire logic           RST_,
  input  wire logic           fifoempty,
  input  wire logic           fifofull,
  input  wire logic           clr_int,
  input  wire logic           istr_rd,    // Level for whole ISTR read
  input  wire logic           intena,
  input  wire logic           inta_i,     // Interrupt request in
  output sdmac_reg_pkg::istr_t istr_o,
  output logic                int_o_
);
  import sdmac_reg_pkg::*;

  logic pending;
  logic empty_q;   // FIFO flag snapshot
  logic full_q;

  always_ff @(posedge CLK) begin
    if (!RST_) begin
      pending <= 1'b0;
    end else if (inta_i) begin
      pending <= 1'b1;  // Request wins over clear
    end else if (clr_int) begin
      pending <= 1'b0;
    end
  end

  // Flags frozen while the CPU reads ISTR
  always_ff @(posedge CLK) begin
    if (!istr_rd) begin
      empty_q <= fifoempty;
      full_q  <= fifofull;
    end
  end

  always_comb begin
    istr_o            = '0;  // Unused bits read 0
    istr_o.fifo_empty = empty_q;
    istr_o.fifo_full  = full_q;
    istr_o.intp       = pending;
    istr_o.int_f      = pending & intena;
  end

  // Active low to the CPU
  assign int_o_ = ~(pending & intena);

endmodule

`default_nettype wire

/* registers/registers_term.sv */
// Acknowledge timer. reg_dsk_ falls a fixed number of cycles into an access.
// Never acknowledges the SCSI window, that chip answers itself.
`include "sdmac_config.svh"
`default_nettype none

module registers_term (
  input  wire logic CLK,
  input  wire logic RST_,
  input  wire logic as_,
  input  wire logic dmac_,
  input  wire logic wdregreq,
  input  wire logic h_0c,
  output logic      reg_dsk_
);
  localparam logic [2:0] DLY_STD = 3'(`SDMAC_DSACK_DLY);
  localparam logic [2:0] DLY_ACR = 3'(`SDMAC_DSACK_DLY_ACR);

  logic       access;
  logic [2:0] cnt;     // Edges seen in this access, saturates
  logic [2:0] dly;

  assign access = ~as_ & ~dmac_;
  assign dly    = h_0c ? DLY_ACR : DLY_STD;

  always_ff @(posedge CLK) begin
    if (!RST_) begin
      cnt      <= '0;
      reg_dsk_ <= 1'b1;
    end else if (!access) begin
      cnt      <= '0;
      reg_dsk_ <= 1'b1;  // Release as soon as as_ is seen high
    end else begin
      if (cnt != 3'd7) begin
        cnt <= cnt + 3'd1;
      end
      if (!wdregreq && (cnt >= dly)) begin
        reg_dsk_ <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* registers/registers.sv */
// Host register block of the SCSI DMA controller, top level.
// FIFO, byte pointer, DMA engine and SCSI chip sit outside on plain ports.
`include "sdmac_config.svh"
`default_nettype none

module registers (
  input  wire logic                     CLK,
  input  wire logic                     RST_,
  input  wire logic [7:0]               addr,
  input  wire logic                     dmac_,
  input  wire logic                     as_,
  input  wire logic                     rw,
  input  wire logic [31:0]              mid,       // CPU write data
  input  wire logic                     stopflush, // Flush done
  input  wire logic                     fifoempty,
  input  wire logic                     fifofull,
  input  wire logic                     inta_i,
  output logic      [`SDMAC_DATA_W-1:0] reg_od,    // CPU read data
  output logic                          preset,
  output logic                          flushfifo,
  output logic                          acr_wr,    // To byte pointer
  output logic                          h_0c,      // To byte pointer
  output logic                          a1,
  output logic                          int_o_,
  output logic                          dmadir,
  output logic                          dmaena,
  output logic                          reg_dsk_,
  output logic                          wdregreq   // SCSI chip request
);
  import sdmac_reg_pkg::*;
  import sdmac_bus_pkg::*;

  localparam int CNTR_PAD = `SDMAC_DATA_W - $bits(cntr_t);
  localparam int ISTR_PAD = `SDMAC_DATA_W - $bits(istr_t);

  reg_sel_e   reg_sel;
  cntr_t      cntr_o;
  istr_t      istr_o;
  logic [7:0] sspbdat;
  logic       cntr_wr, sspbdat_wr, istr_rd, intena;
  logic       st_dma, sp_dma, clr_int, flush;  // Action strobes

  addr_decoder u_addr_decoder (
    .CLK(CLK), .RST_(RST_), .addr(addr), .dmac_(dmac_), .as_(as_), .rw(rw),
    .reg_sel(reg_sel), .cntr_wr(cntr_wr), .acr_wr(acr_wr), .sspbdat_wr(sspbdat_wr),
    .st_dma(st_dma), .sp_dma(sp_dma), .clr_int(clr_int), .flush(flush),
    .istr_rd(istr_rd), .h_0c(h_0c), .wdregreq(wdregreq)
  );

  registers_cntr u_registers_cntr (
    .CLK(CLK), .RST_(RST_), .cntr_wr(cntr_wr), .st_dma(st_dma), .sp_dma(sp_dma),
    .mid(mid[8:0]), .cntr_o(cntr_o), .intena(intena), .preset(preset),
    .dmadir(dmadir), .dmaena(dmaena)
  );

  registers_istr u_registers_istr (
    .CLK(CLK), .RST_(RST_), .fifoempty(fifoempty), .fifofull(fifofull),
    .clr_int(clr_int), .istr_rd(istr_rd), .intena(intena), .inta_i(inta_i),
    .istr_o(istr_o), .int_o_(int_o_)
  );

  registers_term u_registers_term (
    .CLK(CLK), .RST_(RST_), .as_(as_), .dmac_(dmac_), .wdregreq(wdregreq),
    .h_0c(h_0c), .reg_dsk_(reg_dsk_)
  );

  always_ff @(posedge CLK) begin
    if (!RST_) begin
      flushfifo <= 1'b0;
      a1        <= 1'b0;
      sspbdat   <= 8'h00;
    end else begin
      if (flush) begin
        flushfifo <= 1'b1;  // New flush beats stopflush
      end else if (stopflush) begin
        flushfifo <= 1'b0;
      end
      if (acr_wr) begin
        a1 <= mid[25];      // Address bit 1 as written to ACR
      end
      if (sspbdat_wr) begin
        sspbdat <= mid[7:0];
      end
    end
  end

  // Read mux, zero when nothing readable is selected
  always_comb begin
    case (reg_sel)
      SEL_WTC:     reg_od = `SDMAC_WTC_VALUE;
      SEL_CNTR:    reg_od = {{CNTR_PAD{1'b0}}, cntr_o};
      SEL_ISTR:    reg_od = {{ISTR_PAD{1'b0}}, istr_o};
      SEL_SSPBDAT: reg_od = {{(`SDMAC_DATA_W - 8){1'b0}}, sspbdat};
      default:     reg_od = '0;
    endcase
  end

endmodule

`default_nettype wire

/* testbench/tb_registers.sv */
// Testbench for the SDMAC host register block. Stops at the first failing check.
// Inputs change 2 ns after the rising edge, the model updates 1 ns after it.
`include "sdmac_config.svh"
`default_nettype none

module tb_registers;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 400;  // ~40 accesses of up to 8 cycles, plus reset
  localparam int WINDOW_HOLD    = 10;   // SCSI window access ended by the CPU side

  logic        CLK = 1'b0;
  logic        RST_;
  logic [7:0]  addr;
  logic        dmac_, as_, rw;
  logic [31:0] mid;
  logic        stopflush, fifoempty, fifofull, inta_i;
  logic [31:0] reg_od;
  logic        preset, flushfifo, acr_wr, h_0c, a1, int_o_;
  logic        dmadir, dmaena, reg_dsk_, wdregreq;

  // Reference model state
  logic [8:0]  exp_cntr;
  logic [7:0]  exp_sspbdat;
  logic        exp_dmaena, exp_flush, exp_a1, exp_pending;
  logic [31:0] lfsr = 32'h4e0e694e;
  int          cycle_count = 0;
  int          acr_pulses = 0;  // Cycles with acr_wr seen high
  logic [31:0] rnd;

  registers DUT (
    .CLK(CLK), .RST_(RST_), .addr(addr), .dmac_(dmac_), .as_(as_), .rw(rw), .mid(mid),
    .stopflush(stopflush), .fifoempty(fifoempty), .fifofull(fifofull), .inta_i(inta_i),
    .reg_od(reg_od), .preset(preset), .flushfifo(flushfifo), .acr_wr(acr_wr),
    .h_0c(h_0c), .a1(a1), .int_o_(int_o_), .dmadir(dmadir), .dmaena(dmaena),
    .reg_dsk_(reg_dsk_), .wdregreq(wdregreq)
  );

  always #20 CLK = ~CLK;  // 40 ns period

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first failing check");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else fail_run($sformatf("MISMATCH %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp)
      else fail_run($sformatf("MISMATCH %s expected %h got %h", name, exp, act));
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};  // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Wait for an edge, then apply the register rules to what that edge sampled
  task automatic next_edge(input logic first);
    logic wr;
    @(posedge CLK);
    #1;
    wr = first & ~rw;
    if (wr && addr == `SDMAC_OFS_CNTR) exp_cntr = mid[8:0];
    if (wr && addr == `SDMAC_OFS_SSPBDAT) exp_sspbdat = mid[7:0];
    if (wr && addr == `SDMAC_OFS_ACR) exp_a1 = mid[25];
    if (first && addr == `SDMAC_OFS_SP_DMA) exp_dmaena = 1'b0;  // Stop wins
    else if (first && addr == `SDMAC_OFS_ST_DMA) exp_dmaena = 1'b1;
    if (first && addr == `SDMAC_OFS_FLUSH) exp_flush = 1'b1;
    else if (stopflush) exp_flush = 1'b0;
    if (inta_i) exp_pending = 1'b1;  // Request beats clear
    else if (first && addr == `SDMAC_OFS_CINT) exp_pending = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) next_edge(1'b0);
    #1;
  endtask

  // One CPU access, starting and ending 2 ns after an edge
  task automatic bus_cycle(input logic [7:0] a, input logic rd, input logic [31:0] d,
                           output logic [31:0] rdata);
    int   n;
    int   exp_dly;
    int   exp_acr;
    int   acr_before;
    logic window;
    window     = (a >= `SDMAC_WD_LO) && (a <= `SDMAC_WD_HI);
    exp_dly    = (a == `SDMAC_OFS_ACR) ? `SDMAC_DSACK_DLY_ACR : `SDMAC_DSACK_DLY;
    exp_acr    = (!rd && a == `SDMAC_OFS_ACR) ? 1 : 0;  // ACR write strobes once
    acr_before = acr_pulses;
    addr  = a;
    rw    = rd;
    mid   = d;
    as_   = 1'b0;
    dmac_ = 1'b0;
    n     = 0;
    do begin
      next_edge(n == 0);
      n++;
      check_bit("wdregreq", window, wdregreq);
      check_bit("h_0c", a == `SDMAC_OFS_ACR, h_0c);
    end while (reg_dsk_ && n < WINDOW_HOLD);
    rdata = reg_od;
    if (window) begin
      assert (reg_dsk_) else fail_run("reg_dsk_ fell inside the SCSI chip window");
    end else begin
      check_word("reg_dsk_ delay", 32'(exp_dly), 32'(n - 1));  // Counted from first edge
    end
    check_word("acr_wr pulses", 32'(exp_acr), 32'(acr_pulses - acr_before));
    #1;
    as_   = 1'b1;
    dmac_ = 1'b1;
    rw    = 1'b1;
    idle(1);  // reg_dsk_ released here
  endtask

  task automatic bus_write(input logic [7:0] a, input logic [31:0] d);
    logic [31:0] unused_rd;
    bus_cycle(a, 1'b0, d, unused_rd);
  endtask

  task automatic bus_read(input logic [7:0] a, input logic [31:0] exp);
    logic [31:0] rdata;
    bus_cycle(a, 1'b1, 32'h0, rdata);
    check_word("reg_od", exp, rdata);
  endtask

  function automatic logic [31:0] istr_word();
    return {23'b0, exp_pending & exp_cntr[2], 3'b0, exp_pending, 2'b0, fifofull, fifoempty};
  endfunction

  task automatic check_reset_state();
    check_bit("int_o_", 1'b1, int_o_);
    check_bit("reg_dsk_", 1'b1, reg_dsk_);
    check_bit("dmaena", 1'b0, dmaena);
    check_bit("preset", 1'b0, preset);
    check_bit("flushfifo", 1'b0, flushfifo);
    check_bit("wdregreq", 1'b0, wdregreq);
    check_bit("acr_wr", 1'b0, acr_wr);
  endtask

  // Mid-cycle compare of all level outputs against the model
  always @(negedge CLK) begin
    if (RST_) begin
      check_bit("dmaena", exp_dmaena, dmaena);
      check_bit("dmadir", exp_cntr[1], dmadir);
      check_bit("preset", exp_cntr[4], preset);
      check_bit("flushfifo", exp_flush, flushfifo);
      check_bit("a1", exp_a1, a1);
      check_bit("int_o_", ~(exp_pending & exp_cntr[2]), int_o_);
      if (acr_wr) acr_pulses++;  // One negedge per strobe cycle
    end
  end

  ack_release: assert property (@(posedge CLK) disable iff (!RST_) as_ |=> reg_dsk_)
    else fail_run("reg_dsk_ still low a cycle after as_ rose");
  window_no_ack: assert property (@(posedge CLK) disable iff (!RST_) wdregreq |-> reg_dsk_)
    else fail_run("reg_dsk_ low during a SCSI window access");
  acr_one_pulse: assert property (@(posedge CLK) disable iff (!RST_) acr_wr |=> !acr_wr)
    else fail_run("acr_wr held for more than one cycle");

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) fail_run("timeout, run did not finish in time");
  end

  initial begin
    RST_ = 1'b0;
    addr = 8'h00;
    dmac_ = 1'b1;
    as_ = 1'b1;
    rw = 1'b1;
    mid = 32'h0;
    stopflush = 1'b0;
    fifoempty = 1'b1;
    fifofull = 1'b0;
    inta_i = 1'b0;
    {exp_cntr, exp_sspbdat, exp_dmaena, exp_flush, exp_a1, exp_pending} = '0;
    repeat (8) @(posedge CLK);  // 8 cycles of reset
    #2;
    RST_ = 1'b1;
    check_reset_state();
    bus_read(`SDMAC_OFS_WTC, 32'd4);
    bus_read(`SDMAC_OFS_CNTR, 32'h0);
    bus_read(`SDMAC_OFS_SSPBDAT, 32'h0);
    repeat (3) begin  // Random CNTR, upper bits dropped
      take_bits(32, rnd);
      bus_write(`SDMAC_OFS_CNTR, rnd);
      bus_read(`SDMAC_OFS_CNTR, {23'b0, exp_cntr});
    end
    repeat (2) begin
      take_bits(32, rnd);
      bus_write(`SDMAC_OFS_SSPBDAT, rnd);
      bus_read(`SDMAC_OFS_SSPBDAT, {24'b0, exp_sspbdat});
    end
    take_bits(32, rnd);
    bus_write(`SDMAC_OFS_ACR, rnd | 32'h0200_0000);  // a1 to 1, slow ack
    bus_write(`SDMAC_OFS_ACR, rnd & ~32'h0200_0000);
    bus_write(`SDMAC_OFS_CNTR, 32'h0000_00A5);
    bus_write(`SDMAC_OFS_ST_DMA, 32'h0);
    bus_read(`SDMAC_OFS_CNTR, {23'b0, exp_cntr});  // Untouched by strobes
    bus_write(`SDMAC_OFS_SP_DMA, 32'h0);
    bus_read(`SDMAC_OFS_CNTR, {23'b0, exp_cntr});
    bus_write(`SDMAC_OFS_CNTR, 32'h0000_0004);  // Interrupt enable only
    inta_i = 1'b1;
    idle(2);
    bus_read(`SDMAC_OFS_ISTR, istr_word());
    bus_write(`SDMAC_OFS_CINT, 32'h0);  // Ignored, request still high
    inta_i = 1'b0;
    idle(1);
    bus_write(`SDMAC_OFS_CINT, 32'h0);
    bus_read(`SDMAC_OFS_ISTR, istr_word());
    bus_write(`SDMAC_OFS_CNTR, 32'h0);  // Masked, pending still visible
    inta_i = 1'b1;
    idle(2);
    bus_read(`SDMAC_OFS_ISTR, istr_word());
    inta_i = 1'b0;
    fifoempty = 1'b0;
    fifofull = 1'b1;
    idle(1);
    bus_write(`SDMAC_OFS_CINT, 32'h0);
    bus_read(`SDMAC_OFS_ISTR, istr_word());
    bus_write(`SDMAC_OFS_FLUSH, 32'h0);
    idle(3);  // Latch holds
    stopflush = 1'b1;
    idle(1);
    stopflush = 1'b0;
    idle(1);
    bus_read(8'h44, 32'h0);  // SCSI window, no local ack
    bus_write(8'h4F, 32'h1234_5678);
    idle(2);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/sdmac_reg_pkg.sv
common/sdmac_bus_pkg.sv
registers/addr_decoder.sv
registers/registers_cntr.sv
registers/registers_istr.sv
registers/registers_term.sv
registers/registers.sv
testbench/tb_registers.sv

/* Makefile */
# Verilator build and run for the SDMAC host register block
TOP = tb_registers

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f

run: build
	./obj_dir/V$(TOP) 2>&1 | tee run.log
	@grep -q "=== PASS ===" run.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir run.log

.PHONY: all build run lint clean
